// ==== Makefile ====
# Verilator build and run for the motor drive core.

TOP       ?= motorDriveTb
SEED      ?= 2205
LOG       ?= sim.log
VERILATOR ?= verilator
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= TEST RESULT: PASS
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+design
design/motor_pkg.sv
design/commutationSequencer.sv
design/runControl.sv
design/gateDriver.sv
design/motorDriveTop.sv
bench/motorDrive_properties.sv
bench/motorDriveTb.sv

// ==== bench/motorDriveTb.sv ====
`timescale 1ns/1ns

`include "motor_config.svh"

module motorDriveTb
    import motor_pkg::*;
();

    localparam int PRESCALE = `STEP_PRESCALE;
    localparam int DEAD = `DEAD_TIME;
    localparam int BRAKE = `BRAKE_CYCLES;
    localparam int MAX_TESTS = 32;
    localparam gatePattern_t BRAKE_GATES = 6'b010101;

    logic         clk50mhz;
    logic         rstN;
    logic         start;
    logic         invOrStop;
    freqWord_t    freq;
    logic         aH;
    logic         aL;
    logic         bH;
    logic         bL;
    logic         cH;
    logic         cL;
    gatePattern_t gates;

    string        testNames [MAX_TESTS];
    int           testFreq [MAX_TESTS];
    int           testRev [MAX_TESTS];
    int           testSteps [MAX_TESTS];
    int           testDistinct [MAX_TESTS];
    int           testCount;
    int           watchdogCycles;
    int           errorCount;
    int           cycleCount;
    int unsigned  lcgState;

    assign gates = {aH, aL, bH, bL, cH, cL};

    initial clk50mhz = 1'b0;
    always #4 clk50mhz = ~clk50mhz;

    motorDriveTop motorDriveTop_inst (
        .clk50mhz   (   clk50mhz    ),
        .rstN       (   rstN        ),
        .start      (   start       ),
        .invOrStop  (   invOrStop   ),
        .freq       (   freq        ),
        .aH         (   aH          ),
        .aL         (   aL          ),
        .bH         (   bH          ),
        .bL         (   bL          ),
        .cH         (   cH          ),
        .cL         (   cL          )
    );

    // Forward commutation table, bits aH aL bH bL cH cL.
    function automatic gatePattern_t tablePattern(input int idx);
        case (idx)
            0:       return 6'b100100;
            1:       return 6'b100001;
            2:       return 6'b001001;
            3:       return 6'b011000;
            4:       return 6'b010010;
            5:       return 6'b000110;
            default: return 6'b000000;
        endcase
    endfunction

    function automatic int tableIndex(input gatePattern_t pat);
        for (int i = 0; i < 6; i++) begin
            if (tablePattern(i) == pat) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;
    endfunction

    task automatic checkValue(input string testName, input string what,
                              input int expected, input int actual);
        if (expected !== actual) begin
            errorCount++;
            $display("Fail %s %s: expected %0d, actual %0d", testName, what, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic advanceCycle();
        @(posedge clk50mhz);
        #1;
        cycleCount++;
    endtask

    // Lines starting with # are comments.
    task automatic readGolden();
        int    fd;
        int    n;
        int    f;
        int    r;
        int    s;
        int    d;
        string line;
        string name;
        fd = $fopen("bench/motor_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file bench/motor_golden.txt");
            $display("TEST RESULT: FAIL");
            $fatal(1, "golden file missing");
        end
        testCount = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %d %d %d %d", name, f, r, s, d);
                if (n == 5 && testCount < MAX_TESTS) begin
                    testNames[testCount] = name;
                    testFreq[testCount] = f;
                    testRev[testCount] = r;
                    testSteps[testCount] = s;
                    testDistinct[testCount] = d;
                    testCount++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic stopWithBrake(input string name, input int rev, input gatePattern_t lastOn);
        int offCnt;
        int brakeLen;
        offCnt = 0;
        brakeLen = 0;
        if (rev != 0) begin
            start = 1'b0;
        end else begin
            invOrStop = 1'b1;
        end
        while (gates == lastOn) begin
            advanceCycle();
        end
        checkValue(name, "gates after stop request", 0, int'(gates));
        while (gates == '0) begin
            offCnt++;
            advanceCycle();
        end
        checkValue(name, "dead time before brake", DEAD, offCnt);
        checkValue(name, "brake pattern", int'(BRAKE_GATES), int'(gates));
        while (gates == BRAKE_GATES) begin
            brakeLen++;
            // A start pulse in the middle of the brake.
            if (brakeLen == 20 || brakeLen == 30) begin
                start = ~start;
            end
            advanceCycle();
        end
        // Pattern shows DEAD+1 after braking rises and drops 1 after it falls.
        checkValue(name, "brake cycles", BRAKE - DEAD, brakeLen);
        repeat (50) begin
            checkValue(name, "gates after brake", 0, int'(gates));
            advanceCycle();
        end
    endtask

    task automatic runTest(input string name, input int freqVal, input int rev,
                           input int steps, input int expDistinct, input int idleGap);
        gatePattern_t prev;
        gatePattern_t lastOn;
        int           offRun;
        int           lastOnset;
        int           onsets;
        int           transitions;
        int           seenMask;
        int           idx;
        int           prevIdx;
        int           wantIdx;
        prev = '0;
        lastOn = '0;
        offRun = 0;
        lastOnset = 0;
        onsets = 0;
        transitions = 0;
        seenMask = 0;
        prevIdx = 0;
        $display("Running %s with freq %0d, reverse %0d", name, freqVal, rev);
        freq = freqWord_t'(freqVal);
        invOrStop = rev[0];
        start = 1'b0;
        repeat (idleGap) begin
            advanceCycle();
            checkValue(name, "idle gates", 0, int'(gates));
        end
        start = 1'b1;
        while ((freqVal != 0) ? (transitions < steps) : (onsets == 0)) begin
            advanceCycle();
            if (gates != '0 && gates != prev) begin
                checkValue(name, "all off before a new pattern", 0, int'(prev));
                idx = tableIndex(gates);
                checkValue(name, "pattern found in table", 1, int'(idx >= 0));
                if (onsets > 0) begin
                    wantIdx = (rev != 0) ? (prevIdx + 5) % 6 : (prevIdx + 1) % 6;
                    checkValue(name, "table index of next pattern", wantIdx, idx);
                    checkValue(name, "dead time cycles", DEAD, offRun);
                    transitions++;
                end
                // The first onset is not aligned to the sector grid.
                if (onsets > 1) begin
                    checkValue(name, "cycles between steps", (freqVal + 1) * PRESCALE,
                               cycleCount - lastOnset);
                end
                seenMask |= 1 << idx;
                lastOn = gates;
                prevIdx = idx;
                lastOnset = cycleCount;
                onsets++;
            end
            if (gates == '0) begin
                offRun++;
            end else begin
                offRun = 0;
            end
            prev = gates;
        end
        if (freqVal == 0) begin
            repeat (steps * 2 * PRESCALE) begin
                advanceCycle();
                checkValue(name, "held pattern", int'(lastOn), int'(gates));
            end
        end
        checkValue(name, "distinct patterns", expDistinct, $countones(seenMask));
        stopWithBrake(name, rev, lastOn);
    endtask

    initial begin
        int watch;
        watch = 0;
        wait (watchdogCycles > 0);
        watch = watchdogCycles;
        repeat (watch) @(posedge clk50mhz);
        $display("Timeout: the tests did not finish within %0d clock cycles", watch);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int maxPeriod;
        int sumSteps;
        int freqVal;
        int gap;
        rstN = 1'b0;
        start = 1'b0;
        invOrStop = 1'b0;
        freq = '0;
        errorCount = 0;
        cycleCount = 0;
        watchdogCycles = 0;
        lcgState = 32'd2205;
        maxPeriod = 2 * PRESCALE;
        sumSteps = 0;
        readGolden();
        if (testCount == 0) begin
            $display("The golden file holds no test lines");
            $display("TEST RESULT: FAIL");
            $fatal(1, "no tests");
        end
        for (int i = 0; i < testCount; i++) begin
            sumSteps += testSteps[i];
            if ((testFreq[i] + 1) * PRESCALE > maxPeriod) begin
                maxPeriod = (testFreq[i] + 1) * PRESCALE;
            end
        end
        watchdogCycles = sumSteps * maxPeriod * 2 + testCount * (2 * BRAKE + 400) + 2000;
        repeat (4) @(posedge clk50mhz);
        #1;
        rstN = 1'b1;
        repeat (30) begin
            advanceCycle();
            checkValue("resetIdle", "gates", 0, int'(gates));
        end
        for (int i = 0; i < testCount; i++) begin
            // For random lines the freq column is the largest value to pick.
            if (testNames[i].len() >= 6 && testNames[i].substr(0, 5) == "random") begin
                freqVal = 1 + int'(nextRandom() % testFreq[i]);
                gap = 10 + int'(nextRandom() % 40);
            end else begin
                freqVal = testFreq[i];
                gap = 20;
            end
            runTest(testNames[i], freqVal, testRev[i], testSteps[i], testDistinct[i], gap);
        end
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/motorDrive_properties.sv ====
`timescale 1ns/1ns

`include "motor_config.svh"

module motorDrive_properties
    import motor_pkg::*;
(
    input logic clk50mhz,
    input logic rstN,
    input logic aH,
    input logic aL,
    input logic bH,
    input logic bL,
    input logic cH,
    input logic cL
);

    gatePattern_t gates;
    int           offRun;

    assign gates = {aH, aL, bH, bL, cH, cL};

    // Consecutive all-off samples, saturating.
    always_ff @(posedge clk50mhz or negedge rstN) begin
        if (!rstN) begin
            offRun <= 0;
        end else if (gates != '0) begin
            offRun <= 0;
        end else if (offRun < 1000) begin
            offRun <= offRun + 1;
        end
    end

    noShootThrough: assert property (
        @(posedge clk50mhz) disable iff (!rstN)
        !(aH && aL) && !(bH && bL) && !(cH && cL)
    ) else $error("High and low gate of one phase are on together: %b", gates);

    oneHighSide: assert property (
        @(posedge clk50mhz) disable iff (!rstN)
        $onehot0({aH, bH, cH})
    ) else $error("More than one high gate is on: %b", gates);

    // A new conducting pattern only appears after the dead time of all off.
    deadTimeGap: assert property (
        @(posedge clk50mhz) disable iff (!rstN)
        (gates != '0 && gates != $past(gates)) |-> ($past(gates) == '0 && offRun >= `DEAD_TIME)
    ) else $error("Gate pattern %b appeared without a full dead time", gates);

endmodule

bind motorDriveTop motorDrive_properties motorDriveProps (
    .clk50mhz   (   clk50mhz    ),
    .rstN       (   rstN        ),
    .aH         (   aH          ),
    .aL         (   aL          ),
    .bH         (   bH          ),
    .bL         (   bL          ),
    .cH         (   cH          ),
    .cL         (   cL          )
);

// ==== bench/motor_golden.txt ====
# Columns: test name, freq, reverse flag, steps to observe, distinct conducting patterns.
# Steps count pattern changes; for random lines freq is the upper bound of the random pick.
fwdSlow   3 0 8 6
fwdFast   1 0 7 6
revSlow   2 1 8 6
revFast   1 1 6 6
fwdShort  4 0 3 4
revShort  1 1 2 3
holdFwd   0 0 10 1
holdRev   0 1 10 1
random1   6 0 6 6
random2   6 1 7 6
random3   6 0 9 6
random4   6 1 5 6
random5   6 0 6 6

// ==== design/commutationSequencer.sv ====
`timescale 1ns/1ns

`include "motor_config.svh"

module commutationSequencer
    import motor_pkg::*;
(
    input  logic      clk50mhz,
    input  logic      rstN,
    input  freqWord_t freq,
    output sector_t   sector
);

    localparam int PRESCALE = `STEP_PRESCALE;
    localparam int PRE_W = $clog2(PRESCALE + 1);

    logic [PRE_W-1:0] preCnt;
    logic             tick;
    freqWord_t        stepCnt;
    logic             holdSector;

    // A zero frequency word freezes the whole timing chain.
    assign holdSector = (freq == '0);

    assign tick = !holdSector && (preCnt == PRE_W'(PRESCALE - 1));

    always_ff @(posedge clk50mhz or negedge rstN) begin
        if (!rstN) begin
            preCnt <= '0;
        end else if (!holdSector) begin
            if (tick) begin
                preCnt <= '0;
            end else begin
                preCnt <= preCnt + 1'b1;
            end
        end
    end

    // Count freq+1 ticks per sector. The >= guards against
    // a freq that drops below the running count.
    always_ff @(posedge clk50mhz or negedge rstN) begin
        if (!rstN) begin
            stepCnt <= '0;
            sector  <= '0;
        end else if (tick) begin
            if (stepCnt >= freq) begin
                stepCnt <= '0;
                if (sector == SECTOR_LAST) begin
                    sector <= '0;
                end else begin
                    sector <= sector + 1'b1;
                end
            end else begin
                stepCnt <= stepCnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/gateDriver.sv ====
`timescale 1ns/1ns

`include "motor_config.svh"

module gateDriver
    import motor_pkg::*;
(
    input  logic         clk50mhz,
    input  logic         rstN,
    input  sector_t      sector,
    input  logic         running,
    input  logic         reverse,
    input  logic         braking,
    output gatePattern_t gates
);

    localparam int DEAD = `DEAD_TIME;
    localparam int DEAD_W = $clog2(DEAD + 1);

    sector_t          tableIdx;
    gatePattern_t     desired;
    gatePattern_t     target;
    logic [DEAD_W-1:0] deadCnt;
    logic             inDead;
    logic             loadTarget;

    // Reverse walks the table backwards: 0, 5, 4, 3, 2, 1.
    always_comb begin
        if (reverse && sector != '0) begin
            tableIdx = sector_t'(3'd6 - sector);
        end else begin
            tableIdx = sector;
        end
    end

    always_comb begin
        if (running) begin
            desired = sectorPattern(tableIdx);
        end else if (braking) begin
            desired = GATES_BRAKE;
        end else begin
            desired = GATES_OFF;
        end
    end

    assign inDead = (deadCnt != '0);

    // A new conducting target starts or restarts the dead time.
    always_comb begin
        if (desired == GATES_OFF) begin
            loadTarget = 1'b0;
        end else if (inDead) begin
            loadTarget = (desired != target);
        end else begin
            loadTarget = (desired != gates);
        end
    end

    always_ff @(posedge clk50mhz) begin
        if (loadTarget) begin
            target <= desired;
        end
    end

    always_ff @(posedge clk50mhz or negedge rstN) begin
        if (!rstN) begin
            gates   <= GATES_OFF;
            deadCnt <= '0;
        end else if (desired == GATES_OFF) begin
            // Turning off never waits.
            gates   <= GATES_OFF;
            deadCnt <= '0;
        end else if (loadTarget) begin
            gates   <= GATES_OFF;
            deadCnt <= DEAD_W'(DEAD);
        end else if (inDead) begin
            if (deadCnt == DEAD_W'(1)) begin
                gates <= target;
            end
            deadCnt <= deadCnt - 1'b1;
        end
    end

endmodule

// ==== design/motorDriveTop.sv ====
`timescale 1ns/1ns

`include "motor_config.svh"

module motorDriveTop
    import motor_pkg::*;
(
    input  logic      clk50mhz,
    input  logic      rstN,
    input  logic      start,
    input  logic      invOrStop,
    input  freqWord_t freq,
    output logic      aH,
    output logic      aL,
    output logic      bH,
    output logic      bL,
    output logic      cH,
    output logic      cL
);

    sector_t      sector;
    logic         running;
    logic         reverse;
    logic         braking;
    gatePattern_t gates;

    commutationSequencer seq (
        .clk50mhz   (   clk50mhz    ),
        .rstN       (   rstN        ),
        .freq       (   freq        ),
        .sector     (   sector      )
    );

    runControl ctrl (
        .clk50mhz   (   clk50mhz    ),
        .rstN       (   rstN        ),
        .start      (   start       ),
        .invOrStop  (   invOrStop   ),
        .running    (   running     ),
        .reverse    (   reverse     ),
        .braking    (   braking     )
    );

    gateDriver drv (
        .clk50mhz   (   clk50mhz    ),
        .rstN       (   rstN        ),
        .sector     (   sector      ),
        .running    (   running     ),
        .reverse    (   reverse     ),
        .braking    (   braking     ),
        .gates      (   gates       )
    );

    assign {aH, aL, bH, bL, cH, cL} = gates;

endmodule

// ==== design/motor_config.svh ====
`ifndef MOTOR_CONFIG_SVH
`define MOTOR_CONFIG_SVH

// Clock cycles per prescaler tick.
`define STEP_PRESCALE 50

// All-off cycles between two different conducting patterns.
`define DEAD_TIME 8

// Clock cycles the low-side brake is held after a stop.
`define BRAKE_CYCLES 400

`endif

// ==== design/motor_pkg.sv ====
package motor_pkg;

    // Step period in prescaler ticks, zero holds the sector.
    typedef logic [9:0] freqWord_t;

    // Commutation sector, only 0 to 5 are used.
    typedef logic [2:0] sector_t;

    // Gate bits from MSB down: aH, aL, bH, bL, cH, cL.
    typedef logic [5:0] gatePattern_t;

    typedef enum logic [1:0] {
        stIdle  = 2'd0,
        stRun   = 2'd1,
        stBrake = 2'd2
    } runState_t;

    // Highest sector before the counter wraps.
    localparam sector_t SECTOR_LAST = 3'd5;

    // All switches open.
    localparam gatePattern_t GATES_OFF = 6'b000000;

    // All three low sides on, shorting the windings.
    localparam gatePattern_t GATES_BRAKE = 6'b010101;

    // Conducting pattern for one sector of the forward sequence.
    function automatic gatePattern_t sectorPattern(input sector_t idx);
        gatePattern_t pat;
        case (idx)
            3'd0:    pat = 6'b100100;
            3'd1:    pat = 6'b100001;
            3'd2:    pat = 6'b001001;
            3'd3:    pat = 6'b011000;
            3'd4:    pat = 6'b010010;
            3'd5:    pat = 6'b000110;
            default: pat = GATES_OFF;
        endcase
        return pat;
    endfunction

endpackage

// ==== design/runControl.sv ====
`timescale 1ns/1ns

`include "motor_config.svh"

module runControl
    import motor_pkg::*;
(
    input  logic clk50mhz,
    input  logic rstN,
    input  logic start,
    input  logic invOrStop,
    output logic running,
    output logic reverse,
    output logic braking
);

    localparam int BRAKE_LEN = `BRAKE_CYCLES;
    localparam int BRK_W = $clog2(BRAKE_LEN + 1);

    logic             startQ;
    logic             startPrev;
    logic             invQ;
    logic             invPrev;
    logic             startRise;
    logic             stopReq;
    logic [BRK_W-1:0] brakeCnt;
    runState_t        state;

    // Input register stage plus a delayed copy for edges.
    always_ff @(posedge clk50mhz or negedge rstN) begin
        if (!rstN) begin
            startQ    <= 1'b0;
            startPrev <= 1'b0;
            invQ      <= 1'b0;
            invPrev   <= 1'b0;
        end else begin
            startQ    <= start;
            startPrev <= startQ;
            invQ      <= invOrStop;
            invPrev   <= invQ;
        end
    end

    // Registered events, so the machine acts two cycles after sampling.
    always_ff @(posedge clk50mhz or negedge rstN) begin
        if (!rstN) begin
            startRise <= 1'b0;
            stopReq   <= 1'b0;
        end else begin
            startRise <= startQ && !startPrev;
            stopReq   <= (invQ && !invPrev) || (!startQ && startPrev);
        end
    end

    always_ff @(posedge clk50mhz or negedge rstN) begin
        if (!rstN) begin
            state    <= stIdle;
            reverse  <= 1'b0;
            brakeCnt <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (startRise) begin
                        state   <= stRun;
                        // Direction is fixed for the whole run.
                        reverse <= invQ;
                    end
                end
                stRun: begin
                    if (stopReq) begin
                        state    <= stBrake;
                        brakeCnt <= BRK_W'(BRAKE_LEN - 1);
                    end
                end
                stBrake: begin
                    if (brakeCnt == '0) begin
                        state <= stIdle;
                    end else begin
                        brakeCnt <= brakeCnt - 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    assign running = (state == stRun);
    assign braking = (state == stBrake);

endmodule
